/* hw/calc_macros.svh */
// Calculator sizing values: data width, register index width and pipeline depths

`ifndef CALC_MACROS_SVH
`define CALC_MACROS_SVH

// Data word width
`define CALC_XLEN 32

// Register index width, 32 architectural registers
`define CALC_REG_ADDR_W 5

// Completion stages between the reservation register and writeback
`define CALC_COMP_DEPTH 3

// Multiply latency in register stages, reservation register included
`define CALC_MUL_STAGES 3

`endif

/* hw/calc_isa_pkg.sv */
// Calculator ISA package: operation encoding and register-level vector types

`default_nettype none

`include "calc_macros.svh"

package calc_isa_pkg;

  // One data word
  typedef logic [`CALC_XLEN-1:0] calc_data_t;

  // Full unsigned product of two data words
  typedef logic [2*`CALC_XLEN-1:0] calc_product_t;

  // Register index, index 0 is the zero register
  typedef logic [`CALC_REG_ADDR_W-1:0] calc_reg_addr_t;

  // Shift amount, low bits of operand b
  typedef logic [$clog2(`CALC_XLEN)-1:0] calc_shamt_t;

  // Integer pipe takes add through sltu, multiply pipe takes mul and mulhu
  typedef enum logic [3:0]
  {
    e_op_add   = 4'h0,
    e_op_sub   = 4'h1,
    e_op_and   = 4'h2,
    e_op_or    = 4'h3,
    e_op_xor   = 4'h4,
    e_op_sll   = 4'h5,
    e_op_srl   = 4'h6,
    e_op_sltu  = 4'h7,
    e_op_mul   = 4'h8,
    e_op_mulhu = 4'h9
  } calc_op_e;

endpackage

`default_nettype wire

/* hw/calc_pipe_pkg.sv */
// Calculator pipeline package: packets passed between blocks and to the outside

`default_nettype none

package calc_pipe_pkg;

  // Dispatch packet, also the reservation register contents
  typedef struct packed
  {
    logic                         valid;
    logic                         poison;
    calc_isa_pkg::calc_op_e       op;
    logic                         use_imm;
    calc_isa_pkg::calc_reg_addr_t rs1_addr;
    calc_isa_pkg::calc_reg_addr_t rs2_addr;
    calc_isa_pkg::calc_reg_addr_t rd_addr;
    calc_isa_pkg::calc_data_t     rs1_data;
    calc_isa_pkg::calc_data_t     rs2_data;
    calc_isa_pkg::calc_data_t     imm;
  } calc_dispatch_t;

  // Execution pipe result toward completion
  typedef struct packed
  {
    logic                     valid;
    calc_isa_pkg::calc_data_t data;
  } calc_result_t;

  // Forwarding source from completion back to operand issue
  typedef struct packed
  {
    logic                         valid;
    calc_isa_pkg::calc_reg_addr_t rd_addr;
    calc_isa_pkg::calc_data_t     data;
  } calc_fwd_t;

  // Register file writeback
  typedef struct packed
  {
    logic                         valid;
    calc_isa_pkg::calc_reg_addr_t rd_addr;
    calc_isa_pkg::calc_data_t     data;
  } calc_wb_t;

endpackage

`default_nettype wire

/* hw/calc_operand_issue.sv */
// Operand issue: forwards newer results over stale operands and registers the packet

`default_nettype none
`timescale 1ns/100ps

`include "calc_macros.svh"

module calc_operand_issue
(
  input  logic                                          clk_i,
  input  logic                                          rst_i,
  input  calc_pipe_pkg::calc_dispatch_t                 dispatch_i,
  input  calc_pipe_pkg::calc_fwd_t [`CALC_COMP_DEPTH:0] fwd_i,
  output calc_pipe_pkg::calc_dispatch_t                 reservation_o
);

  calc_pipe_pkg::calc_dispatch_t reservation_n;
  calc_pipe_pkg::calc_dispatch_t reservation_r;

  // Lower index is younger, so scan oldest first and let later matches win
  function automatic calc_isa_pkg::calc_data_t bypass
  (
    input calc_isa_pkg::calc_reg_addr_t                addr,
    input calc_isa_pkg::calc_data_t                    data,
    input calc_pipe_pkg::calc_fwd_t [`CALC_COMP_DEPTH:0] fwd
  );
    calc_isa_pkg::calc_data_t sel;
    sel = data;
    for (int i = `CALC_COMP_DEPTH; i >= 0; i--)
    begin
      if (fwd[i].valid && (fwd[i].rd_addr == addr))
      begin
        sel = fwd[i].data;
      end
    end
    // Zero register always reads zero
    if (addr == '0)
    begin
      sel = '0;
    end
    return sel;
  endfunction

  always_comb
  begin
    reservation_n          = dispatch_i;
    reservation_n.rs1_data = bypass(dispatch_i.rs1_addr, dispatch_i.rs1_data, fwd_i);
    // Operand b travels in rs2_data from here on
    reservation_n.rs2_data = dispatch_i.use_imm
                             ? dispatch_i.imm
                             : bypass(dispatch_i.rs2_addr, dispatch_i.rs2_data, fwd_i);
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      reservation_r.valid <= 1'b0;
    end
    else
    begin
      reservation_r <= reservation_n;
    end
  end

  assign reservation_o = reservation_r;

endmodule

`default_nettype wire

/* hw/calc_pipe_int.sv */
// Integer pipe: single-cycle ALU from the reservation register into completion stage 1

`default_nettype none
`timescale 1ns/100ps

module calc_pipe_int
(
  input  calc_pipe_pkg::calc_dispatch_t reservation_i,
  output calc_pipe_pkg::calc_result_t   result_o
);

  calc_isa_pkg::calc_data_t  op_a;
  calc_isa_pkg::calc_data_t  op_b;
  calc_isa_pkg::calc_shamt_t shamt;
  calc_isa_pkg::calc_data_t  alu_data;
  logic                      is_int;

  assign op_a  = reservation_i.rs1_data;
  assign op_b  = reservation_i.rs2_data;
  assign shamt = op_b[$bits(calc_isa_pkg::calc_shamt_t)-1:0];

  always_comb
  begin
    is_int   = 1'b1;
    alu_data = '0;
    case (reservation_i.op)
      calc_isa_pkg::e_op_add:  alu_data = op_a + op_b;
      calc_isa_pkg::e_op_sub:  alu_data = op_a - op_b;
      calc_isa_pkg::e_op_and:  alu_data = op_a & op_b;
      calc_isa_pkg::e_op_or:   alu_data = op_a | op_b;
      calc_isa_pkg::e_op_xor:  alu_data = op_a ^ op_b;
      calc_isa_pkg::e_op_sll:  alu_data = op_a << shamt;
      calc_isa_pkg::e_op_srl:  alu_data = op_a >> shamt;
      calc_isa_pkg::e_op_sltu: alu_data = calc_isa_pkg::calc_data_t'(op_a < op_b);
      // Multiplies and unused encodings belong elsewhere
      default:                 is_int   = 1'b0;
    endcase
  end

  assign result_o.valid = reservation_i.valid & is_int;
  assign result_o.data  = alu_data;

endmodule

`default_nettype wire

/* hw/calc_pipe_mul.sv */
// Multiply pipe: fixed-latency unsigned multiply returning the low or high product word

`default_nettype none
`timescale 1ns/100ps

`include "calc_macros.svh"

module calc_pipe_mul
(
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  calc_pipe_pkg::calc_dispatch_t reservation_i,
  output calc_pipe_pkg::calc_result_t   result_o
);

  // Reservation and operand registers take two stages, product registers the rest
  localparam int prod_stages_lp = `CALC_MUL_STAGES - 2;

  typedef struct packed
  {
    logic                     valid;
    logic                     high;
    calc_isa_pkg::calc_data_t op_a;
    calc_isa_pkg::calc_data_t op_b;
  } mul_opnd_t;

  typedef struct packed
  {
    logic                        valid;
    logic                        high;
    calc_isa_pkg::calc_product_t product;
  } mul_prod_t;

  mul_opnd_t                      opnd_n;
  mul_opnd_t                      opnd_r;
  mul_prod_t [prod_stages_lp-1:0] prod_r;
  calc_isa_pkg::calc_product_t    product;
  mul_prod_t                      prod_last;

  assign opnd_n.valid = reservation_i.valid
                        & ((reservation_i.op == calc_isa_pkg::e_op_mul)
                        | (reservation_i.op == calc_isa_pkg::e_op_mulhu));
  assign opnd_n.high  = (reservation_i.op == calc_isa_pkg::e_op_mulhu);
  assign opnd_n.op_a  = reservation_i.rs1_data;
  assign opnd_n.op_b  = reservation_i.rs2_data;

  assign product = calc_isa_pkg::calc_product_t'(opnd_r.op_a)
                   * calc_isa_pkg::calc_product_t'(opnd_r.op_b);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      opnd_r.valid <= 1'b0;
      for (int i = 0; i < prod_stages_lp; i++)
      begin
        prod_r[i].valid <= 1'b0;
      end
    end
    else
    begin
      opnd_r    <= opnd_n;
      prod_r[0] <= '{valid: opnd_r.valid, high: opnd_r.high, product: product};
      for (int i = 1; i < prod_stages_lp; i++)
      begin
        prod_r[i] <= prod_r[i-1];
      end
    end
  end

  assign prod_last      = prod_r[prod_stages_lp-1];
  assign result_o.valid = prod_last.valid;
  assign result_o.data  = prod_last.high
                          ? prod_last.product[2*`CALC_XLEN-1:`CALC_XLEN]
                          : prod_last.product[`CALC_XLEN-1:0];

endmodule

`default_nettype wire

/* hw/calc_completion.sv */
// Completion pipe: merges pipe results in order, applies poison and flush, drives writeback

`default_nettype none
`timescale 1ns/100ps

`include "calc_macros.svh"

module calc_completion
(
  input  logic                                          clk_i,
  input  logic                                          rst_i,
  input  calc_pipe_pkg::calc_dispatch_t                 reservation_i,
  input  logic                                          flush_i,
  input  calc_pipe_pkg::calc_result_t                   int_result_i,
  input  calc_pipe_pkg::calc_result_t                   mul_result_i,
  output calc_pipe_pkg::calc_fwd_t [`CALC_COMP_DEPTH:0] fwd_o,
  output calc_pipe_pkg::calc_wb_t                       wb_o
);

  localparam int depth_lp = `CALC_COMP_DEPTH;

  // data_v marks that the result has been produced by its pipe
  typedef struct packed
  {
    logic                         wen;
    logic                         data_v;
    calc_isa_pkg::calc_reg_addr_t rd_addr;
    calc_isa_pkg::calc_data_t     data;
  } comp_stage_t;

  comp_stage_t [depth_lp:1] stage_n;
  comp_stage_t [depth_lp:1] stage_r;

  always_comb
  begin
    stage_n[1].wen     = reservation_i.valid & ~reservation_i.poison
                         & (reservation_i.rd_addr != '0);
    stage_n[1].data_v  = 1'b0;
    stage_n[1].rd_addr = reservation_i.rd_addr;
    stage_n[1].data    = '0;
    for (int i = 2; i <= depth_lp; i++)
    begin
      stage_n[i] = stage_r[i-1];
    end

    // Single issue with fixed latency keeps these two from landing on the same instruction
    if (int_result_i.valid)
    begin
      stage_n[1].data_v = 1'b1;
      stage_n[1].data   = int_result_i.data;
    end
    if (mul_result_i.valid)
    begin
      stage_n[depth_lp].data_v = 1'b1;
      stage_n[depth_lp].data   = mul_result_i.data;
    end

    // Flush kills the reservation entry and completion stage 1
    stage_n[1].wen = stage_n[1].wen & ~flush_i;
    stage_n[2].wen = stage_n[2].wen & ~flush_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      for (int i = 1; i <= depth_lp; i++)
      begin
        stage_r[i].wen    <= 1'b0;
        stage_r[i].data_v <= 1'b0;
      end
    end
    else
    begin
      stage_r <= stage_n;
    end
  end

  // Next-state stages first, youngest at index 0, then the writeback stage
  always_comb
  begin
    for (int i = 1; i <= depth_lp; i++)
    begin
      fwd_o[i-1].valid   = stage_n[i].wen & stage_n[i].data_v;
      fwd_o[i-1].rd_addr = stage_n[i].rd_addr;
      fwd_o[i-1].data    = stage_n[i].data;
    end
    fwd_o[depth_lp].valid   = stage_r[depth_lp].wen & stage_r[depth_lp].data_v;
    fwd_o[depth_lp].rd_addr = stage_r[depth_lp].rd_addr;
    fwd_o[depth_lp].data    = stage_r[depth_lp].data;
  end

  assign wb_o.valid   = stage_r[depth_lp].wen;
  assign wb_o.rd_addr = stage_r[depth_lp].rd_addr;
  assign wb_o.data    = stage_r[depth_lp].data;

endmodule

`default_nettype wire

/* hw/calc_top.sv */
// Calculator top: operand issue, integer and multiply pipes, and the completion pipe

`default_nettype none
`timescale 1ns/100ps

`include "calc_macros.svh"

module calc_top
(
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  calc_pipe_pkg::calc_dispatch_t dispatch_i,
  input  logic                          flush_i,
  output calc_pipe_pkg::calc_wb_t       wb_o
);

  calc_pipe_pkg::calc_dispatch_t                 reservation;
  calc_pipe_pkg::calc_result_t                   int_result;
  calc_pipe_pkg::calc_result_t                   mul_result;
  calc_pipe_pkg::calc_fwd_t [`CALC_COMP_DEPTH:0] fwd;

  calc_operand_issue i_operand_issue
  (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .dispatch_i    (dispatch_i),
    .fwd_i         (fwd),
    .reservation_o (reservation)
  );

  // Integer result is ready in the reservation cycle
  calc_pipe_int i_pipe_int
  (
    .reservation_i (reservation),
    .result_o      (int_result)
  );

  calc_pipe_mul i_pipe_mul
  (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .reservation_i (reservation),
    .result_o      (mul_result)
  );

  calc_completion i_completion
  (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .reservation_i (reservation),
    .flush_i       (flush_i),
    .int_result_i  (int_result),
    .mul_result_i  (mul_result),
    .fwd_o         (fwd),
    .wb_o          (wb_o)
  );

endmodule

`default_nettype wire

/* dv/calc_tb.sv */
// Calculator testbench: directed and LFSR-driven tests checked against a register model

`default_nettype none
`timescale 1ns/100ps

module calc_tb;

  typedef struct packed
  {
    int          due;
    logic        valid;
    logic [4:0]  rd;
    logic [31:0] data;
  } exp_wb_t;

  logic                          clk;
  logic                          rst;
  logic                          flush;
  calc_pipe_pkg::calc_dispatch_t dispatch;
  calc_pipe_pkg::calc_wb_t       wb;

  // Program-order values for prediction, and values as written back
  logic [31:0] arch_regs [32];
  logic [31:0] rf_regs [32];
  int          mul_ready [32];
  exp_wb_t     exp_q [$];
  logic [31:0] lfsr_state;
  string       test_name;
  int          cyc;
  int          mismatches;
  int          other_errors;
  logic        pend_valid;
  logic [4:0]  pend_rd;
  logic [31:0] pend_data;

  calc_top i_dut
  (
    .clk_i      (clk),
    .rst_i      (rst),
    .dispatch_i (dispatch),
    .flush_i    (flush),
    .wb_o       (wb)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #50 clk = ~clk;
    end
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      r          = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic logic [31:0] predict(input calc_isa_pkg::calc_op_e op,
                                          input logic [31:0] a, input logic [31:0] b);
    logic [63:0] prod;
    logic [31:0] r;
    prod = {32'h0, a} * {32'h0, b};
    case (op)
      calc_isa_pkg::e_op_add:   r = a + b;
      calc_isa_pkg::e_op_sub:   r = a - b;
      calc_isa_pkg::e_op_and:   r = a & b;
      calc_isa_pkg::e_op_or:    r = a | b;
      calc_isa_pkg::e_op_xor:   r = a ^ b;
      calc_isa_pkg::e_op_sll:   r = a << b[4:0];
      calc_isa_pkg::e_op_srl:   r = a >> b[4:0];
      calc_isa_pkg::e_op_sltu:  r = (a < b) ? 32'd1 : 32'd0;
      calc_isa_pkg::e_op_mul:   r = prod[31:0];
      calc_isa_pkg::e_op_mulhu: r = prod[63:32];
      default:                  r = 32'h0;
    endcase
    return r;
  endfunction

  task automatic check(input string what, input logic [31:0] exp_v, input logic [31:0] act_v);
    if (exp_v !== act_v)
    begin
      mismatches++;
      $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp_v, act_v);
    end
  endtask

  // One clock edge, then compare wb against whatever is due this cycle
  task automatic tick();
    exp_wb_t e;
    @(posedge clk);
    #1;
    // Register file write takes effect at the end of the writeback cycle
    if (pend_valid)
    begin
      rf_regs[pend_rd] = pend_data;
    end
    cyc++;
    if ((exp_q.size() != 0) && (exp_q[0].due == cyc))
    begin
      e = exp_q.pop_front();
      check("wb valid", 32'(e.valid), 32'(wb.valid));
      if (e.valid)
      begin
        check("wb rd", 32'(e.rd), 32'(wb.rd_addr));
        check("wb data", e.data, wb.data);
      end
    end
    else
    begin
      check("idle wb valid", 32'h0, 32'(wb.valid));
    end
    pend_valid = wb.valid;
    pend_rd    = wb.rd_addr;
    pend_data  = wb.data;
  endtask

  task automatic idle();
    dispatch = '0;
    flush    = 1'b0;
    tick();
  endtask

  task automatic issue(input calc_isa_pkg::calc_op_e op, input logic [4:0] rd,
                       input logic [4:0] rs1, input logic [4:0] rs2, input logic use_imm,
                       input logic [31:0] imm, input logic poison = 1'b0,
                       input logic kill = 1'b0, input logic flush_now = 1'b0);
    logic [31:0] b;
    exp_wb_t     e;
    b       = use_imm ? imm : arch_regs[rs2];
    e.due   = cyc + 4;
    e.valid = !poison && !kill && (rd != 5'd0);
    e.rd    = rd;
    e.data  = predict(op, arch_regs[rs1], b);
    exp_q.push_back(e);
    if (e.valid)
    begin
      arch_regs[rd] = e.data;
    end
    if ((op == calc_isa_pkg::e_op_mul) || (op == calc_isa_pkg::e_op_mulhu))
    begin
      mul_ready[rd] = cyc + 3;
    end
    dispatch.valid    = 1'b1;
    dispatch.poison   = poison;
    dispatch.op       = op;
    dispatch.use_imm  = use_imm;
    dispatch.rs1_addr = rs1;
    dispatch.rs2_addr = rs2;
    dispatch.rd_addr  = rd;
    // Junk on register 0 reads, the DUT must ignore it
    dispatch.rs1_data = (rs1 == 5'd0) ? rand_bits(32) : rf_regs[rs1];
    dispatch.rs2_data = (rs2 == 5'd0) ? rand_bits(32) : rf_regs[rs2];
    dispatch.imm      = imm;
    flush             = flush_now;
    tick();
  endtask

  task automatic drain();
    for (int g = 0; (g < 8) && (exp_q.size() != 0); g++)
    begin
      idle();
    end
    if (exp_q.size() != 0)
    begin
      other_errors++;
      $display("Timeout in %s: %0d writebacks never arrived", test_name, exp_q.size());
      exp_q.delete();
    end
  endtask

  task automatic test_int_ops();
    test_name = "int_ops";
    for (int i = 0; i < 24; i++)
    begin
      issue(calc_isa_pkg::calc_op_e'(4'(i / 3)), 5'(rand_bits(5)), 5'(rand_bits(5)),
            5'(rand_bits(5)), 1'(rand_bits(1)), rand_bits(32));
    end
    drain();
  endtask

  task automatic test_mul();
    test_name = "mul";
    issue(calc_isa_pkg::e_op_add, 5'd1, 5'd0, 5'd0, 1'b1, 32'hFFFF_FFFF);
    issue(calc_isa_pkg::e_op_add, 5'd2, 5'd0, 5'd0, 1'b1, 32'h8000_0001);
    issue(calc_isa_pkg::e_op_mul, 5'd16, 5'd1, 5'd2, 1'b0, 32'h0);
    issue(calc_isa_pkg::e_op_mulhu, 5'd17, 5'd1, 5'd2, 1'b0, 32'h0);
    issue(calc_isa_pkg::e_op_mulhu, 5'd18, 5'd2, 5'd0, 1'b1, 32'hC000_0003);
    // Sources below r16, results at r16 and up, so no multiply reads another
    for (int i = 0; i < 8; i++)
    begin
      issue(calc_isa_pkg::calc_op_e'(4'(8 + i % 2)), 5'(16 + rand_bits(4)),
            5'(1 + rand_bits(4) % 15), 5'(1 + rand_bits(4) % 15), 1'b0, 32'h0);
    end
    drain();
  endtask

  task automatic test_fwd_chain();
    test_name = "fwd_chain";
    issue(calc_isa_pkg::e_op_add, 5'd3, 5'd1, 5'd0, 1'b1, 32'h0000_1234);
    issue(calc_isa_pkg::e_op_sub, 5'd4, 5'd3, 5'd1, 1'b0, 32'h0);
    issue(calc_isa_pkg::e_op_xor, 5'd5, 5'd4, 5'd3, 1'b0, 32'h0);
    issue(calc_isa_pkg::e_op_sll, 5'd6, 5'd5, 5'd4, 1'b0, 32'h0);
    issue(calc_isa_pkg::e_op_srl, 5'd7, 5'd6, 5'd0, 1'b1, 32'd3);
    issue(calc_isa_pkg::e_op_sltu, 5'd8, 5'd7, 5'd6, 1'b0, 32'h0);
    // Same destination four times in flight, the youngest must win
    repeat (4)
    begin
      issue(calc_isa_pkg::e_op_add, 5'd3, 5'd3, 5'd0, 1'b1, 32'd1);
    end
    issue(calc_isa_pkg::e_op_or, 5'd9, 5'd3, 5'd8, 1'b0, 32'h0);
    drain();
  endtask

  task automatic test_mul_fwd_zero();
    test_name = "mul_fwd_zero";
    issue(calc_isa_pkg::e_op_mul, 5'd10, 5'd1, 5'd2, 1'b0, 32'h0);
    idle();
    idle();
    issue(calc_isa_pkg::e_op_add, 5'd11, 5'd10, 5'd0, 1'b0, 32'h0);
    issue(calc_isa_pkg::e_op_or, 5'd12, 5'd10, 5'd0, 1'b1, 32'h0F0F_0000);
    issue(calc_isa_pkg::e_op_sub, 5'd13, 5'd10, 5'd12, 1'b0, 32'h0);
    issue(calc_isa_pkg::e_op_add, 5'd0, 5'd1, 5'd2, 1'b0, 32'h0);
    issue(calc_isa_pkg::e_op_add, 5'd14, 5'd0, 5'd0, 1'b0, 32'h0);
    issue(calc_isa_pkg::e_op_xor, 5'd15, 5'd0, 5'd0, 1'b1, 32'hA5A5_5A5A);
    drain();
  endtask

  task automatic test_flush_poison();
    test_name = "flush_poison";
    issue(calc_isa_pkg::e_op_add, 5'd20, 5'd1, 5'd0, 1'b1, 32'h1111_1111, 1'b0, 1'b1);
    issue(calc_isa_pkg::e_op_add, 5'd21, 5'd2, 5'd0, 1'b1, 32'h2222_2222, 1'b0, 1'b1);
    issue(calc_isa_pkg::e_op_add, 5'd22, 5'd20, 5'd21, 1'b0, 32'h0, 1'b0, 1'b0, 1'b1);
    issue(calc_isa_pkg::e_op_xor, 5'd23, 5'd20, 5'd21, 1'b0, 32'h0);
    issue(calc_isa_pkg::e_op_sub, 5'd24, 5'd1, 5'd0, 1'b1, 32'h5, 1'b1);
    issue(calc_isa_pkg::e_op_add, 5'd25, 5'd24, 5'd0, 1'b1, 32'h0);
    drain();
  endtask

  task automatic test_random_stream();
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic       use_imm;
    test_name = "random_stream";
    for (int i = 0; i < 60; i++)
    begin
      rd      = 5'(rand_bits(5));
      rs1     = 5'(rand_bits(5));
      rs2     = 5'(rand_bits(5));
      use_imm = 1'(rand_bits(1));
      // Hold a consumer back until the multiply result reaches stage 3
      for (int g = 0; (g < 4) && ((mul_ready[rs1] > cyc)
           || (!use_imm && (mul_ready[rs2] > cyc))); g++)
      begin
        idle();
      end
      if (rand_bits(2) == 32'd0)
      begin
        idle();
      end
      issue(calc_isa_pkg::calc_op_e'(4'(rand_bits(4) % 10)), rd, rs1, rs2, use_imm,
            rand_bits(32), rand_bits(3) == 32'd0);
    end
    drain();
  endtask

  initial
  begin
    rst          = 1'b1;
    flush        = 1'b0;
    dispatch     = '0;
    lfsr_state   = 32'h2182;
    cyc          = 0;
    mismatches   = 0;
    other_errors = 0;
    pend_valid   = 1'b0;
    test_name    = "reset";
    arch_regs[0] = 32'h0;
    rf_regs[0]   = 32'h0;
    for (int r = 1; r < 32; r++)
    begin
      arch_regs[r] = rand_bits(32);
      rf_regs[r]   = arch_regs[r];
    end
    for (int r = 0; r < 32; r++)
    begin
      mul_ready[r] = 0;
    end
    repeat (10)
    begin
      tick();
    end
    rst = 1'b0;
    test_int_ops();
    test_mul();
    test_fwd_chain();
    test_mul_fwd_zero();
    test_flush_poison();
    test_random_stream();
    $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
    if ((mismatches == 0) && (other_errors == 0))
    begin
      $display("PASS: all tests");
    end
    else
    begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+hw
hw/calc_isa_pkg.sv
hw/calc_pipe_pkg.sv
hw/calc_operand_issue.sv
hw/calc_pipe_int.sv
hw/calc_pipe_mul.sv
hw/calc_completion.sv
hw/calc_top.sv
dv/calc_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the calculator testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f list.f --top-module calc_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out="$(./obj_dir/Vcalc_tb)"
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "PASS: all tests" <<< "$sim_out"; then
  exit 0
fi
exit 1
